// ==== rtl/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

  // bus widths
  localparam int ADDR_W = 16;  // port and register address width
  localparam int DATA_W = 16;  // data word and register width

  // host register map, one word each
  localparam logic [ADDR_W-1:0] REG_CTRL = 16'hFFF0;  // control word
  localparam logic [ADDR_W-1:0] REG_SI   = 16'hFFF1;  // source index
  localparam logic [ADDR_W-1:0] REG_SM   = 16'hFFF2;  // source modifier
  localparam logic [ADDR_W-1:0] REG_SC   = 16'hFFF3;  // source count
  localparam logic [ADDR_W-1:0] REG_DI   = 16'hFFF4;  // destination index
  localparam logic [ADDR_W-1:0] REG_DM   = 16'hFFF5;  // destination modifier
  localparam logic [ADDR_W-1:0] REG_DC   = 16'hFFF6;  // destination count

  // control word fields
  localparam int CTRL_EN      = 0;  // enable, starts a transfer
  localparam int CTRL_PIPE    = 1;  // set: read latency 1, clear: latency 2
  localparam int CTRL_DIR_LSB = 2;  // low bit of the 2-bit direction

  // legal directions, the others never start
  localparam logic [1:0] DIR_INT_TO_EXT = 2'b01;  // np reads, sp writes
  localparam logic [1:0] DIR_EXT_TO_INT = 2'b10;  // sp reads, np writes

  // transfer buffer
  localparam int FIFO_DEPTH = 8;  // entries
  localparam int LVL_W      = 4;  // holds 0..FIFO_DEPTH

endpackage

`default_nettype wire

// ==== rtl/dmaRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaRegs (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      regWr,
  input  logic [dmaPkg::ADDR_W-1:0] regAddr,
  input  logic [dmaPkg::DATA_W-1:0] regWdata,
  input  logic                      done,
  output logic                      busy,
  output logic                      start,
  output logic                      pipe,
  output logic [1:0]                dir,
  output logic [dmaPkg::ADDR_W-1:0] srcBase,
  output logic [dmaPkg::ADDR_W-1:0] srcStep,
  output logic [dmaPkg::DATA_W-1:0] srcCount,
  output logic [dmaPkg::ADDR_W-1:0] dstBase,
  output logic [dmaPkg::ADDR_W-1:0] dstStep,
  output logic [dmaPkg::DATA_W-1:0] dstCount
);

  logic       hostWr;    // write taken, only while idle
  logic       ctrlWr;    // accepted control write
  logic [1:0] newDir;    // direction field of the written word
  logic       dirOk;     // one of the two cross-port codes
  logic       startHit;  // enabling control write with legal direction

  assign hostWr   = regWr && !busy;
  assign ctrlWr   = hostWr && (regAddr == dmaPkg::REG_CTRL);
  assign newDir   = regWdata[dmaPkg::CTRL_DIR_LSB +: 2];
  assign dirOk    = (newDir == dmaPkg::DIR_INT_TO_EXT) || (newDir == dmaPkg::DIR_EXT_TO_INT);
  assign startHit = ctrlWr && regWdata[dmaPkg::CTRL_EN] && dirOk;

  // control state: enable bit, start pulse, mode fields
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy  <= 1'b0;
      start <= 1'b0;
      pipe  <= 1'b0;
      dir   <= 2'b00;
    end
    else
    begin
      start <= startHit;                           // one cycle, same cycle busy rises
      if (startHit)
        busy <= 1'b1;                              // enable bit kept as busy
      else if (done)
        busy <= 1'b0;                              // cleared by the last write
      if (ctrlWr)
      begin
        pipe <= regWdata[dmaPkg::CTRL_PIPE];
        dir  <= newDir;                            // 00/11 kept but never run
      end
    end
  end

  // index, modifier and count words
  always_ff @(posedge clk)
  begin
    if (hostWr)
    begin
      case (regAddr)
        dmaPkg::REG_SI: srcBase  <= regWdata;
        dmaPkg::REG_SM: srcStep  <= regWdata;
        dmaPkg::REG_SC: srcCount <= regWdata;
        dmaPkg::REG_DI: dstBase  <= regWdata;
        dmaPkg::REG_DM: dstStep  <= regWdata;
        dmaPkg::REG_DC: dstCount <= regWdata;
        default: ;                                 // control handled above
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/srcReader.sv ====
`timescale 1ns/1ns
`default_nettype none

module srcReader (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic                      pipe,
  input  logic [dmaPkg::ADDR_W-1:0] srcBase,
  input  logic [dmaPkg::ADDR_W-1:0] srcStep,
  input  logic [dmaPkg::DATA_W-1:0] srcCount,
  input  logic                      portBusy,
  input  logic [dmaPkg::DATA_W-1:0] rdata,
  input  logic [dmaPkg::LVL_W-1:0]  fifoLevel,
  output logic                      reqEn,
  output logic [dmaPkg::ADDR_W-1:0] reqAddr,
  output logic                      push,
  output logic [dmaPkg::DATA_W-1:0] pushData
);

  logic [dmaPkg::ADDR_W-1:0] runAddr;    // next source address
  logic [dmaPkg::DATA_W-1:0] remaining;  // reads still to issue
  logic [dmaPkg::ADDR_W-1:0] effAddr;    // base on start, else running
  logic [dmaPkg::DATA_W-1:0] effCount;   // count on start, else remaining
  logic                      v1;         // read issued one cycle ago
  logic                      v2;         // read issued two cycles ago
  logic [1:0]                pending;    // reads not yet pushed
  logic [dmaPkg::LVL_W-1:0]  committed;  // level plus reads in flight
  logic                      issue;      // register a read this edge

  // start loads and issues in one step, so the first read
  // lands on the port one cycle after start
  assign effAddr  = start ? srcBase : runAddr;
  assign effCount = start ? srcCount : remaining;

  // in flight: request on the port, stage 1, and stage 2 only
  // when latency is 2 (with latency 1 stage 1 pushes this cycle)
  assign pending   = {1'b0, reqEn} + {1'b0, v1} + {1'b0, v2 & ~pipe};
  assign committed = fifoLevel + {{(dmaPkg::LVL_W-2){1'b0}}, pending};

  assign issue = (effCount != '0) && !portBusy && (committed < dmaPkg::FIFO_DEPTH);

  // data returns L cycles after the request cycle
  assign push     = pipe ? v1 : v2;
  assign pushData = rdata;                         // captured by the FIFO on push

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      reqEn     <= 1'b0;
      reqAddr   <= '0;
      runAddr   <= '0;
      remaining <= '0;
      v1        <= 1'b0;
      v2        <= 1'b0;
    end
    else
    begin
      v1 <= reqEn;                                 // valid delay line
      v2 <= v1;
      if (issue)
      begin
        reqEn     <= 1'b1;
        reqAddr   <= effAddr;
        runAddr   <= effAddr + srcStep;            // step by source modifier
        remaining <= effCount - 1'b1;
      end
      else
      begin
        reqEn <= 1'b0;                             // busy, full or finished
        if (start)
        begin
          runAddr   <= srcBase;                    // held back on start cycle
          remaining <= srcCount;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/xferFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module xferFifo (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      push,
  input  logic [dmaPkg::DATA_W-1:0] pushData,
  input  logic                      pop,
  output logic [dmaPkg::DATA_W-1:0] popData,
  output logic                      empty,
  output logic [dmaPkg::LVL_W-1:0]  level
);

  logic [dmaPkg::DATA_W-1:0] mem [dmaPkg::FIFO_DEPTH];   // storage
  logic [$clog2(dmaPkg::FIFO_DEPTH)-1:0] wrPtr;          // next free slot
  logic [$clog2(dmaPkg::FIFO_DEPTH)-1:0] rdPtr;          // head slot

  // head shown ahead of pop
  assign popData = mem[rdPtr];
  assign empty   = (level == '0);

  // reader never pushes into a full buffer, writer never pops empty
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= pushData;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      level <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;                     // depth is a power of two
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;                   // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dstWriter.sv ====
`timescale 1ns/1ns
`default_nettype none

module dstWriter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [dmaPkg::ADDR_W-1:0] dstBase,
  input  logic [dmaPkg::ADDR_W-1:0] dstStep,
  input  logic [dmaPkg::DATA_W-1:0] dstCount,
  input  logic                      portBusy,
  input  logic                      empty,
  input  logic [dmaPkg::DATA_W-1:0] popData,
  output logic                      pop,
  output logic                      wrEn,
  output logic [dmaPkg::ADDR_W-1:0] wrAddr,
  output logic [dmaPkg::DATA_W-1:0] wrData,
  output logic                      done
);

  logic [dmaPkg::ADDR_W-1:0] runAddr;    // address of the next write
  logic [dmaPkg::DATA_W-1:0] remaining;  // writes still owed
  logic                      busyQ;      // port busy taken at the last edge

  // a write goes out in the pop cycle, all terms come from flops
  assign pop    = !empty && !busyQ && (remaining != '0);
  assign wrEn   = pop;
  assign wrAddr = runAddr;
  assign wrData = popData;                         // head of the FIFO
  assign done   = pop && (remaining == (dmaPkg::DATA_W)'(1));   // last word

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      runAddr   <= '0;
      remaining <= '0;
      busyQ     <= 1'b0;
    end
    else
    begin
      busyQ <= portBusy;                           // no write right after busy
      if (start)
      begin
        runAddr   <= dstBase;                      // remaining is zero here
        remaining <= dstCount;
      end
      else if (pop)
      begin
        runAddr   <= runAddr + dstStep;            // step by destination modifier
        remaining <= remaining - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/portSwitch.sv ====
`timescale 1ns/1ns
`default_nettype none

module portSwitch (
  input  logic [1:0]                dir,
  input  logic                      rdEn,
  input  logic [dmaPkg::ADDR_W-1:0] rdAddr,
  input  logic                      wrEn,
  input  logic [dmaPkg::ADDR_W-1:0] wrAddr,
  input  logic [dmaPkg::DATA_W-1:0] wrData,
  input  logic [dmaPkg::DATA_W-1:0] npRdata,
  input  logic [dmaPkg::DATA_W-1:0] spRdata,
  input  logic                      npBusy,
  input  logic                      spBusy,
  output logic                      npEn,
  output logic                      npWr,
  output logic [dmaPkg::ADDR_W-1:0] npAddr,
  output logic [dmaPkg::DATA_W-1:0] npWdata,
  output logic                      spEn,
  output logic                      spWr,
  output logic [dmaPkg::ADDR_W-1:0] spAddr,
  output logic [dmaPkg::DATA_W-1:0] spWdata,
  output logic [dmaPkg::DATA_W-1:0] srcRdata,
  output logic                      srcBusy,
  output logic                      dstBusy
);

  always_comb
  begin
    // idle ports: everything low, addresses zero
    npEn     = 1'b0;
    npWr     = 1'b0;
    npAddr   = '0;
    npWdata  = '0;
    spEn     = 1'b0;
    spWr     = 1'b0;
    spAddr   = '0;
    spWdata  = '0;
    srcRdata = npRdata;
    srcBusy  = npBusy;
    dstBusy  = spBusy;
    case (dir)
      dmaPkg::DIR_INT_TO_EXT:
      begin
        npEn     = rdEn;                           // np is the read side
        npAddr   = rdAddr;
        spEn     = wrEn;                           // sp takes the writes
        spWr     = wrEn;
        spAddr   = wrAddr;
        spWdata  = wrData;
      end
      dmaPkg::DIR_EXT_TO_INT:
      begin
        spEn     = rdEn;                           // sp is the read side
        spAddr   = rdAddr;
        npEn     = wrEn;
        npWr     = wrEn;
        npAddr   = wrAddr;
        npWdata  = wrData;
        srcRdata = spRdata;
        srcBusy  = spBusy;
        dstBusy  = npBusy;
      end
      default: ;                                   // 00 and 11 never run
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dmaTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaTop (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      regWr,
  input  logic [dmaPkg::ADDR_W-1:0] regAddr,
  input  logic [dmaPkg::DATA_W-1:0] regWdata,
  input  logic [dmaPkg::DATA_W-1:0] npRdata,
  input  logic [dmaPkg::DATA_W-1:0] spRdata,
  input  logic                      npBusy,
  input  logic                      spBusy,
  output logic                      npEn,
  output logic                      npWr,
  output logic [dmaPkg::ADDR_W-1:0] npAddr,
  output logic [dmaPkg::DATA_W-1:0] npWdata,
  output logic                      spEn,
  output logic                      spWr,
  output logic [dmaPkg::ADDR_W-1:0] spAddr,
  output logic [dmaPkg::DATA_W-1:0] spWdata,
  output logic                      busy,
  output logic                      done
);

  logic                      start;     // transfer launch pulse
  logic                      pipe;      // read latency select
  logic [1:0]                dir;       // port mapping
  logic [dmaPkg::ADDR_W-1:0] srcBase;
  logic [dmaPkg::ADDR_W-1:0] srcStep;
  logic [dmaPkg::DATA_W-1:0] srcCount;
  logic [dmaPkg::ADDR_W-1:0] dstBase;
  logic [dmaPkg::ADDR_W-1:0] dstStep;
  logic [dmaPkg::DATA_W-1:0] dstCount;
  logic                      rdEn;      // reader request
  logic [dmaPkg::ADDR_W-1:0] rdAddr;
  logic                      push;      // returned word into FIFO
  logic [dmaPkg::DATA_W-1:0] pushData;
  logic                      pop;       // head out to the writer
  logic [dmaPkg::DATA_W-1:0] popData;
  logic                      empty;
  logic [dmaPkg::LVL_W-1:0]  level;
  logic                      wrEn;      // writer request
  logic [dmaPkg::ADDR_W-1:0] wrAddr;
  logic [dmaPkg::DATA_W-1:0] wrData;
  logic [dmaPkg::DATA_W-1:0] srcRdata;  // read data of the source port
  logic                      srcBusy;
  logic                      dstBusy;

  dmaRegs regs (
    .clk(clk), .rst(rst), .regWr(regWr), .regAddr(regAddr), .regWdata(regWdata),
    .done(done), .busy(busy), .start(start), .pipe(pipe), .dir(dir),
    .srcBase(srcBase), .srcStep(srcStep), .srcCount(srcCount),
    .dstBase(dstBase), .dstStep(dstStep), .dstCount(dstCount)
  );

  srcReader reader (
    .clk(clk), .rst(rst), .start(start), .pipe(pipe),
    .srcBase(srcBase), .srcStep(srcStep), .srcCount(srcCount),
    .portBusy(srcBusy), .rdata(srcRdata), .fifoLevel(level),
    .reqEn(rdEn), .reqAddr(rdAddr), .push(push), .pushData(pushData)
  );

  xferFifo fifo (
    .clk(clk), .rst(rst), .push(push), .pushData(pushData), .pop(pop),
    .popData(popData), .empty(empty), .level(level)
  );

  dstWriter writer (
    .clk(clk), .rst(rst), .start(start),
    .dstBase(dstBase), .dstStep(dstStep), .dstCount(dstCount),
    .portBusy(dstBusy), .empty(empty), .popData(popData),
    .pop(pop), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .done(done)
  );

  portSwitch switcher (
    .dir(dir), .rdEn(rdEn), .rdAddr(rdAddr),
    .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
    .npRdata(npRdata), .spRdata(spRdata), .npBusy(npBusy), .spBusy(spBusy),
    .npEn(npEn), .npWr(npWr), .npAddr(npAddr), .npWdata(npWdata),
    .spEn(spEn), .spWr(spWr), .spAddr(spAddr), .spWdata(spWdata),
    .srcRdata(srcRdata), .srcBusy(srcBusy), .dstBusy(dstBusy)
  );

endmodule

`default_nettype wire

// ==== verif/dmaTop_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaTop_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      regWr,
  input logic [dmaPkg::ADDR_W-1:0] regAddr,
  input logic                      npBusy,
  input logic                      spBusy,
  input logic                      npEn,
  input logic                      npWr,
  input logic                      spEn,
  input logic                      spWr,
  input logic                      busy,
  input logic                      done
);

  // a busy port gets nothing in the next cycle
  npHold: assert property (@(posedge clk) disable iff (rst) npBusy |=> !npEn)
    else $error("np request right after np busy");
  spHold: assert property (@(posedge clk) disable iff (rst) spBusy |=> !spEn)
    else $error("sp request right after sp busy");

  oneWriter: assert property (@(posedge clk) disable iff (rst) !(npEn && npWr && spEn && spWr))
    else $error("writes on both ports in one cycle");

  // only a control write can launch
  busyRise: assert property (@(posedge clk) disable iff (rst)
    $rose(busy) |-> $past(regWr && (regAddr == dmaPkg::REG_CTRL)))
    else $error("busy rose without a control write");

  doneInBusy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
    else $error("done outside a transfer");

endmodule

bind dmaTop dmaTop_sva sva (
  .clk(clk), .rst(rst), .regWr(regWr), .regAddr(regAddr), .npBusy(npBusy), .spBusy(spBusy),
  .npEn(npEn), .npWr(npWr), .spEn(spEn), .spWr(spWr), .busy(busy), .done(done)
);

`default_nettype wire

// ==== verif/dmaTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dmaTb;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      regWr;
  logic [dmaPkg::ADDR_W-1:0] regAddr;
  logic [dmaPkg::DATA_W-1:0] regWdata;
  logic [dmaPkg::DATA_W-1:0] npRdata = '0;
  logic [dmaPkg::DATA_W-1:0] spRdata = '0;
  logic                      npBusy = 1'b0;
  logic                      spBusy = 1'b0;
  logic                      npEn, npWr, spEn, spWr, busy, done;
  logic [dmaPkg::ADDR_W-1:0] npAddr, spAddr;
  logic [dmaPkg::DATA_W-1:0] npWdata, spWdata;

  logic [dmaPkg::DATA_W-1:0] npMem [65536];   // internal port memory
  logic [dmaPkg::DATA_W-1:0] spMem [65536];   // external port memory
  logic [dmaPkg::DATA_W-1:0] expMem [65536];  // expected destination image
  logic [dmaPkg::DATA_W-1:0] npLate, spLate;  // second read stage for latency 2
  logic [dmaPkg::ADDR_W-1:0] sBase, sStep, dBase, dStep;
  logic [dmaPkg::DATA_W-1:0] xferCount = '0;  // words in the running transfer
  logic                      dstIsSp;         // writes expected on sp
  logic                      pipeL = 1'b1;    // latency 1 when set
  string                     testName = "reset";
  int                        busyPct = 0;
  int                        wrTotal = 0;     // destination writes seen so far
  int                        wrBase = 0;
  int                        doneTotal = 0;
  int                        doneBase = 0;
  longint                    cycleCount = 0;
  longint                    cycleLimit = 200; // reset phase allowance

  dmaTop DUT (.*);

  always #2 clk = ~clk;

  // port memories: fill on reset, fixed read latency, random busy
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int a = 0; a < 65536; a++)
      begin
        npMem[a] <= 16'(a) ^ 16'h5ac3;
        spMem[a] <= 16'(a * 40503 + 11);            // differs from np at every address
      end
    end
    else
    begin
      if (npEn && npWr)
        npMem[npAddr] <= npWdata;
      if (spEn && spWr)
        spMem[spAddr] <= spWdata;
    end
    npLate  <= npMem[npAddr];
    spLate  <= spMem[spAddr];
    npRdata <= pipeL ? npMem[npAddr] : npLate;
    spRdata <= pipeL ? spMem[spAddr] : spLate;
    npBusy  <= int'($urandom_range(0, 99)) < busyPct;
    spBusy  <= int'($urandom_range(0, 99)) < busyPct;
  end

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  // watchdog, limit grows with every test
  initial
  begin
    wait (cycleCount > cycleLimit);
    $display("run timed out after %0d cycles", cycleCount);
    $display("Test failed");
    $fatal(1);
  end

  task automatic checkWord(input string what, input logic [dmaPkg::DATA_W-1:0] expected,
                           input logic [dmaPkg::DATA_W-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s expected %h actual %h", testName, what, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s expected %b actual %b", testName, what, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // scoreboard: k-th write must land on the k-th destination address
  task automatic noteWrite(input logic toSp, input logic [dmaPkg::ADDR_W-1:0] addr,
                           input logic [dmaPkg::DATA_W-1:0] data);
    logic [dmaPkg::ADDR_W-1:0] k;
    logic [dmaPkg::ADDR_W-1:0] srcAddr;
    k = 16'(wrTotal - wrBase);
    srcAddr = sBase + k * sStep;
    checkBit("write port", dstIsSp, toSp);
    checkWord("write address", dBase + k * dStep, addr);
    checkWord("write data", dstIsSp ? npMem[srcAddr] : spMem[srcAddr], data);
    checkBit("done on last write", k == xferCount - 16'd1, done);  // only the last one
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (done)
      begin
        doneTotal <= doneTotal + 1;
        checkBit("done with a write", 1'b1, (npEn && npWr) || (spEn && spWr));
      end
      if (npEn && npWr)
        noteWrite(1'b0, npAddr, npWdata);
      if (spEn && spWr)
        noteWrite(1'b1, spAddr, spWdata);
      if ((npEn && npWr) || (spEn && spWr))
        wrTotal <= wrTotal + 1;
    end
  end

  function automatic logic [dmaPkg::DATA_W-1:0] ctrlWord(input logic [1:0] dir, input logic pipe);
    logic [dmaPkg::DATA_W-1:0] w;
    w = '0;
    w[dmaPkg::CTRL_EN] = 1'b1;
    w[dmaPkg::CTRL_PIPE] = pipe;
    w[dmaPkg::CTRL_DIR_LSB +: 2] = dir;
    return w;
  endfunction

  // one host write, called on a rising edge
  task automatic regWrite(input logic [dmaPkg::ADDR_W-1:0] addr,
                          input logic [dmaPkg::DATA_W-1:0] data);
    regWr    <= 1'b1;
    regAddr  <= addr;
    regWdata <= data;
    @(posedge clk);
    regWr    <= 1'b0;
  endtask

  task automatic runXfer(input string name, input logic [1:0] dir, input logic pipe,
                         input int pct, input logic meddle);
    logic [dmaPkg::DATA_W-1:0] count;
    testName = name;
    count    = 16'($urandom_range(meddle ? 16 : 1, 40));  // long enough to meddle
    sBase    = 16'($urandom);
    dBase    = 16'($urandom);
    sStep    = 16'($urandom_range(0, 12)) - 16'd4;       // zero and backward steps too
    dStep    = 16'($urandom_range(0, 12)) - 16'd4;
    dstIsSp  = (dir == dmaPkg::DIR_INT_TO_EXT);
    pipeL    = pipe;
    busyPct  = pct;
    wrBase   = wrTotal;
    doneBase = doneTotal;
    xferCount = count;
    cycleLimit = cycleLimit + 40 * longint'(count) + 200;
    for (int a = 0; a < 65536; a++)
      expMem[a] = dstIsSp ? spMem[a] : npMem[a];           // untouched words stay
    for (int k = 0; k < int'(count); k++)
      expMem[dBase + 16'(k) * dStep] = dstIsSp ? npMem[sBase + 16'(k) * sStep]
                                               : spMem[sBase + 16'(k) * sStep];
    regWrite(dmaPkg::REG_SI, sBase);
    regWrite(dmaPkg::REG_SM, sStep);
    regWrite(dmaPkg::REG_SC, count);
    regWrite(dmaPkg::REG_DI, dBase);
    regWrite(dmaPkg::REG_DM, dStep);
    regWrite(dmaPkg::REG_DC, count);
    regWrite(dmaPkg::REG_CTRL, ctrlWord(dir, pipe));
    if (meddle)
      repeat (6) regWrite(dmaPkg::REG_CTRL + 16'($urandom_range(0, 6)), 16'($urandom));
    do
      @(posedge clk);
    while (!done);
    repeat (3) @(posedge clk);                            // last write settled
    checkWord("write count", count, 16'(wrTotal - wrBase));
    checkWord("done pulses", 16'd1, 16'(doneTotal - doneBase));
    checkBit("busy after done", 1'b0, busy);
    for (int a = 0; a < 65536; a++)
      checkWord("image", expMem[a], dstIsSp ? spMem[a] : npMem[a]);
  endtask

  // 00 and 11 must leave both ports quiet
  task automatic illegalStart(input logic [1:0] dir);
    testName   = "illegal direction";
    cycleLimit = cycleLimit + 200;
    regWrite(dmaPkg::REG_CTRL, ctrlWord(dir, 1'b1));
    repeat (12)
    begin
      @(posedge clk);
      checkBit("busy", 1'b0, busy);
      checkBit("np enable", 1'b0, npEn);
      checkBit("sp enable", 1'b0, spEn);
    end
  endtask

  initial
  begin
    void'($urandom(32'hb868));
    rst      <= 1'b1;
    regWr    <= 1'b0;
    regAddr  <= '0;
    regWdata <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkBit("busy", 1'b0, busy);                        // reset state
    checkBit("done", 1'b0, done);
    checkBit("np enable", 1'b0, npEn);
    checkBit("sp enable", 1'b0, spEn);
    checkBit("np write", 1'b0, npWr);
    checkBit("sp write", 1'b0, spWr);
    checkWord("np address", '0, npAddr);
    checkWord("sp address", '0, spAddr);
    runXfer("int to ext", dmaPkg::DIR_INT_TO_EXT, 1'b1, 0, 1'b0);
    repeat (2) runXfer("ext to int", dmaPkg::DIR_EXT_TO_INT, 1'b0, 0, 1'b0);
    repeat (3) runXfer("busy int to ext", dmaPkg::DIR_INT_TO_EXT, 1'b0, 30, 1'b0);
    repeat (3) runXfer("busy ext to int", dmaPkg::DIR_EXT_TO_INT, 1'b1, 30, 1'b0);
    illegalStart(2'b00);
    illegalStart(2'b11);
    runXfer("writes while busy", dmaPkg::DIR_INT_TO_EXT, 1'b1, 30, 1'b1);
    runXfer("writes while busy", dmaPkg::DIR_EXT_TO_INT, 1'b0, 30, 1'b1);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/dmaPkg.sv
rtl/dmaRegs.sv
rtl/srcReader.sv
rtl/xferFifo.sv
rtl/dstWriter.sv
rtl/portSwitch.sv
rtl/dmaTop.sv
verif/dmaTop_sva.sv
verif/dmaTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module dmaTb -f verilog.f -o dmaSim
./obj_dir/dmaSim
